// File: hdl/feature_pkg.sv
package feature_pkg;

    // image geometry
    localparam int IMG_W = 16;
    localparam int IMG_H = 16;

    // keypoint memory capacity
    localparam int KPT_MAX = 64;

    typedef logic [7:0] pixel_t;     // unsigned grey level
    typedef logic [7:0] pix_addr_t;  // row*16 + col
    typedef logic [3:0] coord_t;

    typedef logic [5:0] kpt_addr_t;
    typedef logic [6:0] kpt_count_t; // 0 .. KPT_MAX

    // one stored keypoint, 16 bits
    typedef struct packed {
        coord_t     row;
        coord_t     col;
        logic [7:0] response;        // original minus blur
    } keypoint_t;

    // write request into a pixel memory
    typedef struct packed {
        logic      we;
        pix_addr_t addr;
        pixel_t    data;
    } pix_req_t;

endpackage

// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

    // top level phases
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_BLUR,
        PH_DETECT
    } phase_t;

    typedef logic signed [7:0] thresh_t;

    typedef logic adapt_mode_t;
    localparam adapt_mode_t MODE_THROUGHPUT = 1'b0;
    localparam adapt_mode_t MODE_ACCURACY   = 1'b1;

    // threshold limits and step
    localparam thresh_t THRESH_INIT = 8'sd20;
    localparam thresh_t THRESH_MIN  = 8'sd4;
    localparam thresh_t THRESH_MAX  = 8'sd60;
    localparam thresh_t THRESH_STEP = 8'sd4;

    localparam logic [7:0] CONTRAST_MIN = 8'd16;  // min blurred level

    // target count bands
    localparam logic [6:0] BAND_LO_0 = 7'd4;
    localparam logic [6:0] BAND_HI_0 = 7'd12;
    localparam logic [6:0] BAND_LO_1 = 7'd16;
    localparam logic [6:0] BAND_HI_1 = 7'd40;

endpackage

// File: hdl/sync_ram.sv
`timescale 1ns/1ps

module sync_ram import feature_pkg::*; #(
    parameter type payload_t = pixel_t,
    parameter int  DEPTH     = IMG_W * IMG_H,
    localparam int AW        = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  payload_t      wr_data,
    input  logic [AW-1:0] rd_addr,
    output payload_t      rd_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // old data on collision
    end

endmodule

// File: hdl/gauss_blur.sv
`timescale 1ns/1ps

module gauss_blur import feature_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    output pix_addr_t img_rd_addr,
    input  pixel_t    img_rd_data,
    output pix_req_t  blur_wr,
    output logic      blur_done
);

    localparam coord_t LAST_ROW = coord_t'(IMG_H - 1);
    localparam coord_t LAST_COL = coord_t'(IMG_W - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_TAP,
        S_LAST
    } state_t;

    state_t      state;
    coord_t      row;
    coord_t      col;
    logic [1:0]  tap_r;
    logic [1:0]  tap_c;
    logic [4:0]  nb_row;
    logic [4:0]  nb_col;
    logic        in_img;
    logic [1:0]  shift;
    logic [1:0]  shift_d;
    logic        take_d;
    logic [11:0] acc;
    logic [11:0] term;
    logic [11:0] sum;

    // neighbour position, bit 4 set means outside the image
    assign nb_row = {1'b0, row} + {3'b000, tap_r} - 5'd1;
    assign nb_col = {1'b0, col} + {3'b000, tap_c} - 5'd1;
    assign in_img = !nb_row[4] && !nb_col[4];

    // weights 1 2 1 / 2 4 2 / 1 2 1 as shifts
    assign shift = {1'b0, tap_r == 2'd1} + {1'b0, tap_c == 2'd1};

    assign img_rd_addr = {nb_row[3:0], nb_col[3:0]};

    // data of the previous tap arrives now
    assign term = take_d ? ({4'b0000, img_rd_data} << shift_d) : 12'd0;
    assign sum  = acc + term;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            row       <= '0;
            col       <= '0;
            tap_r     <= '0;
            tap_c     <= '0;
            acc       <= '0;
            take_d    <= 1'b0;
            shift_d   <= '0;
            blur_wr   <= '0;
            blur_done <= 1'b0;
        end else begin
            blur_wr.we <= 1'b0;
            blur_done  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        row    <= '0;
                        col    <= '0;
                        tap_r  <= '0;
                        tap_c  <= '0;
                        acc    <= '0;
                        take_d <= 1'b0;
                        state  <= S_TAP;
                    end
                end
                S_TAP: begin
                    acc     <= sum;
                    take_d  <= in_img;  // zero fill outside
                    shift_d <= shift;
                    if (tap_c == 2'd2) begin
                        tap_c <= '0;
                        tap_r <= tap_r + 2'd1;
                    end else begin
                        tap_c <= tap_c + 2'd1;
                    end
                    if (tap_r == 2'd2 && tap_c == 2'd2) begin
                        state <= S_LAST;
                    end
                end
                S_LAST: begin
                    blur_wr <= '{we: 1'b1, addr: {row, col}, data: sum[11:4]};
                    acc     <= '0;
                    take_d  <= 1'b0;
                    tap_r   <= '0;
                    if (row == LAST_ROW && col == LAST_COL) begin
                        blur_done <= 1'b1;
                        state     <= S_IDLE;
                    end else begin
                        if (col == LAST_COL) begin
                            row <= row + 4'd1;
                        end
                        col   <= col + 4'd1;  // wraps at row end
                        state <= S_TAP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/keypoint_detect.sv
`timescale 1ns/1ps

module keypoint_detect import feature_pkg::*, ctrl_pkg::*; #(
    parameter int KPT_CAP = KPT_MAX
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       filter_on,
    input  thresh_t    thresh,
    output pix_addr_t  img_rd_addr,
    input  pixel_t     img_rd_data,
    output pix_addr_t  blur_rd_addr,
    input  pixel_t     blur_rd_data,
    output logic       kpt_we,
    output kpt_addr_t  kpt_wr_addr,
    output keypoint_t  kpt_wr_data,
    output kpt_count_t kpt_count,
    output logic       detect_done
);

    localparam pix_addr_t LAST_PIX = pix_addr_t'(IMG_W * IMG_H - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_EVAL
    } state_t;

    state_t            state;
    pix_addr_t         pix;
    logic signed [8:0] diff;
    logic              contrast_ok;
    logic              hit;
    logic              room;

    assign img_rd_addr  = pix;
    assign blur_rd_addr = pix;

    assign diff        = $signed({1'b0, img_rd_data}) - $signed({1'b0, blur_rd_data});
    assign contrast_ok = !filter_on || (blur_rd_data >= CONTRAST_MIN);
    assign hit         = (diff > thresh) && contrast_ok;
    assign room        = kpt_count < kpt_count_t'(KPT_CAP);  // drop once full

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            pix         <= '0;
            kpt_count   <= '0;
            kpt_we      <= 1'b0;
            kpt_wr_addr <= '0;
            kpt_wr_data <= '0;
            detect_done <= 1'b0;
        end else begin
            kpt_we      <= 1'b0;
            detect_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        pix       <= '0;
                        kpt_count <= '0;
                        state     <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_EVAL;  // one cycle ram latency
                S_EVAL: begin
                    if (hit && room) begin
                        kpt_we      <= 1'b1;
                        kpt_wr_addr <= kpt_addr_t'(kpt_count);
                        kpt_wr_data <= '{row: pix[7:4], col: pix[3:0], response: diff[7:0]};
                        kpt_count   <= kpt_count + 7'd1;
                    end
                    if (pix == LAST_PIX) begin
                        detect_done <= 1'b1;
                        state       <= S_IDLE;
                    end else begin
                        pix   <= pix + 8'd1;
                        state <= S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/adaptive_threshold.sv
`timescale 1ns/1ps

module adaptive_threshold import ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        update,
    input  logic        adapt_on,
    input  adapt_mode_t adapt_mode,
    input  logic [6:0]  kpt_count,
    output thresh_t     thresh
);

    logic [6:0] band_lo;
    logic [6:0] band_hi;
    thresh_t    thresh_next;

    always_comb begin
        band_lo = BAND_LO_0;
        band_hi = BAND_HI_0;
        case (adapt_mode)
            MODE_THROUGHPUT: begin
                band_lo = BAND_LO_0;
                band_hi = BAND_HI_0;
            end
            MODE_ACCURACY: begin
                band_lo = BAND_LO_1;
                band_hi = BAND_HI_1;
            end
        endcase

        thresh_next = thresh;
        if (kpt_count > band_hi) begin  // too many, be stricter
            thresh_next = (thresh > THRESH_MAX - THRESH_STEP) ? THRESH_MAX
                                                              : thresh + THRESH_STEP;
        end else if (kpt_count < band_lo) begin
            thresh_next = (thresh < THRESH_MIN + THRESH_STEP) ? THRESH_MIN
                                                              : thresh - THRESH_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            thresh <= THRESH_INIT;
        end else if (update && adapt_on) begin
            thresh <= thresh_next;
        end
    end

endmodule

// File: hdl/phase_ctrl.sv
`timescale 1ns/1ps

module phase_ctrl import feature_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      blur_done,
    input  logic      detect_done,
    input  pix_req_t  img_wr,
    input  pix_addr_t blur_img_addr,
    input  pix_addr_t detect_img_addr,
    output phase_t    phase,
    output logic      busy,
    output logic      done,
    output logic      blur_start,
    output logic      detect_start,
    output pix_req_t  img_ram_wr,
    output pix_addr_t img_ram_rd_addr
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase        <= PH_IDLE;
            done         <= 1'b0;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
        end else begin
            done         <= 1'b0;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase      <= PH_BLUR;
                        blur_start <= 1'b1;
                    end
                end
                PH_BLUR: begin
                    if (blur_done) begin
                        phase        <= PH_DETECT;
                        detect_start <= 1'b1;
                    end
                end
                PH_DETECT: begin
                    if (detect_done) begin
                        phase <= PH_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    assign busy = (phase != PH_IDLE);  // start ignored while set

    always_comb begin
        img_ram_wr      = img_wr;
        img_ram_wr.we   = img_wr.we && !busy;  // host writes lost while busy
        img_ram_rd_addr = (phase == PH_BLUR) ? blur_img_addr : detect_img_addr;
    end

endmodule

// File: hdl/feature_core.sv
`timescale 1ns/1ps

module feature_core import feature_pkg::*, ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        filter_on,
    input  logic        adapt_on,
    input  adapt_mode_t adapt_mode,
    input  pix_req_t    img_wr,
    input  kpt_addr_t   kpt_rd_addr,
    output logic        busy,
    output logic        done,
    output kpt_count_t  kpt_count,
    output thresh_t     thresh,
    output keypoint_t   kpt_rd_data
);

    logic      blur_start;
    logic      blur_done;
    logic      detect_start;
    logic      detect_done;
    pix_addr_t blur_img_addr;
    pix_addr_t detect_img_addr;
    pix_addr_t img_rd_addr;
    pix_addr_t blur_rd_addr;
    pix_req_t  img_ram_wr;
    pix_req_t  blur_wr;
    pixel_t    img_rd_data;
    pixel_t    blur_rd_data;
    logic      kpt_we;
    kpt_addr_t kpt_wr_addr;
    keypoint_t kpt_wr_data;

    phase_ctrl u_phase_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .blur_done       (blur_done),
        .detect_done     (detect_done),
        .img_wr          (img_wr),
        .blur_img_addr   (blur_img_addr),
        .detect_img_addr (detect_img_addr),
        .phase           (),
        .busy            (busy),
        .done            (done),
        .blur_start      (blur_start),
        .detect_start    (detect_start),
        .img_ram_wr      (img_ram_wr),
        .img_ram_rd_addr (img_rd_addr)
    );

    gauss_blur u_gauss_blur (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (blur_start),
        .img_rd_addr (blur_img_addr),
        .img_rd_data (img_rd_data),
        .blur_wr     (blur_wr),
        .blur_done   (blur_done)
    );

    keypoint_detect #(
        .KPT_CAP (KPT_MAX)
    ) u_keypoint_detect (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (detect_start),
        .filter_on    (filter_on),
        .thresh       (thresh),
        .img_rd_addr  (detect_img_addr),
        .img_rd_data  (img_rd_data),
        .blur_rd_addr (blur_rd_addr),
        .blur_rd_data (blur_rd_data),
        .kpt_we       (kpt_we),
        .kpt_wr_addr  (kpt_wr_addr),
        .kpt_wr_data  (kpt_wr_data),
        .kpt_count    (kpt_count),
        .detect_done  (detect_done)
    );

    // new threshold for the next run
    adaptive_threshold u_adaptive_threshold (
        .clk        (clk),
        .rst_n      (rst_n),
        .update     (done),
        .adapt_on   (adapt_on),
        .adapt_mode (adapt_mode),
        .kpt_count  (kpt_count),
        .thresh     (thresh)
    );

    sync_ram #(
        .payload_t (pixel_t),
        .DEPTH     (IMG_W * IMG_H)
    ) img_ram (
        .clk     (clk),
        .wr_en   (img_ram_wr.we),
        .wr_addr (img_ram_wr.addr),
        .wr_data (img_ram_wr.data),
        .rd_addr (img_rd_addr),
        .rd_data (img_rd_data)
    );

    sync_ram #(
        .payload_t (pixel_t),
        .DEPTH     (IMG_W * IMG_H)
    ) blur_ram (
        .clk     (clk),
        .wr_en   (blur_wr.we),
        .wr_addr (blur_wr.addr),
        .wr_data (blur_wr.data),
        .rd_addr (blur_rd_addr),
        .rd_data (blur_rd_data)
    );

    sync_ram #(
        .payload_t (keypoint_t),
        .DEPTH     (KPT_MAX)
    ) kpt_ram (
        .clk     (clk),
        .wr_en   (kpt_we),
        .wr_addr (kpt_wr_addr),
        .wr_data (kpt_wr_data),
        .rd_addr (kpt_rd_addr),  // host readback
        .rd_data (kpt_rd_data)
    );

endmodule

// File: test/feature_model.svh
`ifndef FEATURE_MODEL_SVH
`define FEATURE_MODEL_SVH

// golden copies of what the core should compute for one run
pixel_t    model_img  [IMG_W * IMG_H];
pixel_t    model_blur [IMG_W * IMG_H];
keypoint_t model_kpts [KPT_MAX];
int        model_count;  // stored keypoints, capped
int        model_cands;  // all candidates, uncapped

// 3x3 gaussian, zero outside the image, truncating divide by 16
function automatic void compute_blur();
    int r;
    int c;
    int dr;
    int dc;
    int acc;
    int w;
    for (r = 0; r < IMG_H; r++) begin
        for (c = 0; c < IMG_W; c++) begin
            acc = 0;
            for (dr = -1; dr <= 1; dr++) begin
                for (dc = -1; dc <= 1; dc++) begin
                    if (r + dr >= 0 && r + dr < IMG_H && c + dc >= 0 && c + dc < IMG_W) begin
                        w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                        acc += w * int'(model_img[(r + dr) * IMG_W + c + dc]);
                    end
                end
            end
            model_blur[r * IMG_W + c] = pixel_t'(acc >> 4);
        end
    end
endfunction

// raster scan, first KPT_MAX hits kept
function automatic void find_keypoints(input thresh_t th, input logic filt);
    int a;
    int diff;
    model_count = 0;
    model_cands = 0;
    for (a = 0; a < IMG_W * IMG_H; a++) begin
        diff = int'(model_img[a]) - int'(model_blur[a]);
        if (diff > int'(th) && (!filt || model_blur[a] >= CONTRAST_MIN)) begin
            model_cands++;
            if (model_count < KPT_MAX) begin
                model_kpts[model_count] = '{row: coord_t'(a / IMG_W),
                                            col: coord_t'(a % IMG_W),
                                            response: 8'(diff)};
                model_count++;
            end
        end
    end
endfunction

// band compare, step and clamp
function automatic thresh_t next_thresh(input thresh_t th, input logic on,
                                        input adapt_mode_t mode, input int cnt);
    int lo;
    int hi;
    int t;
    lo = (mode == MODE_ACCURACY) ? int'(BAND_LO_1) : int'(BAND_LO_0);
    hi = (mode == MODE_ACCURACY) ? int'(BAND_HI_1) : int'(BAND_HI_0);
    t  = int'(th);
    if (on) begin
        if (cnt > hi) begin
            t = t + int'(THRESH_STEP);
        end else if (cnt < lo) begin
            t = t - int'(THRESH_STEP);
        end
    end
    if (t > int'(THRESH_MAX)) begin
        t = int'(THRESH_MAX);
    end
    if (t < int'(THRESH_MIN)) begin
        t = int'(THRESH_MIN);
    end
    return thresh_t'(t);
endfunction

`endif

// File: test/tb_feature_core.sv
`timescale 1ns/1ps

module tb_feature_core import feature_pkg::*, ctrl_pkg::*; ();

    localparam int NUM_RUNS    = 13;
    localparam int RUN_CYCLES  = 3500;  // blur plus detect, with margin
    localparam int LOAD_CYCLES = 260;
    localparam int READ_CYCLES = 140;
    localparam int MAX_CYCLES  = NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES + READ_CYCLES) + 100;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        filter_on;
    logic        adapt_on;
    adapt_mode_t adapt_mode;
    pix_req_t    img_wr;
    kpt_addr_t   kpt_rd_addr;
    logic        busy;
    logic        done;
    kpt_count_t  kpt_count;
    thresh_t     thresh;
    keypoint_t   kpt_rd_data;

    int      seed;
    int      cycle_count;
    int      done_pulses;
    thresh_t model_thresh;

    `include "feature_model.svh"

    feature_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .filter_on   (filter_on),
        .adapt_on    (adapt_on),
        .adapt_mode  (adapt_mode),
        .img_wr      (img_wr),
        .kpt_rd_addr (kpt_rd_addr),
        .busy        (busy),
        .done        (done),
        .kpt_count   (kpt_count),
        .thresh      (thresh),
        .kpt_rd_data (kpt_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES) begin
            stop_with_failure("timed out, the core never finished its runs");
        end
    end

    always @(negedge clk) begin
        if (done) begin
            done_pulses++;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_count(input kpt_count_t got, input kpt_count_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: kpt_count is %0d, expected %0d", $time, got, exp);
            stop_with_failure("keypoint count mismatch");
        end
    endtask

    task automatic check_keypoint(input int idx, input keypoint_t got, input keypoint_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: keypoint %0d is (%0d,%0d) resp %0d, expected (%0d,%0d) resp %0d",
                     $time, idx, got.row, got.col, got.response,
                     exp.row, exp.col, exp.response);
            stop_with_failure("keypoint record mismatch");
        end
    endtask

    task automatic check_thresh(input thresh_t got, input thresh_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: thresh is %0d, expected %0d", $time, got, exp);
            stop_with_failure("threshold mismatch");
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t: busy is %0b, expected %0b", $time, got, exp);
            stop_with_failure("busy flag mismatch");
        end
    endtask

    function automatic void random_image();
        int a;
        for (a = 0; a < IMG_W * IMG_H; a++) begin
            model_img[a] = pixel_t'($random(seed));
        end
    endfunction

    // bright field, about one pixel in four dark
    function automatic void bright_noisy_image();
        int a;
        for (a = 0; a < IMG_W * IMG_H; a++) begin
            if (($random(seed) & 3) == 0) begin
                model_img[a] = pixel_t'($random(seed) & 15);
            end else begin
                model_img[a] = pixel_t'(200 + ($random(seed) & 31));
            end
        end
    endfunction

    // dark field, about one pixel in eight a medium spot
    function automatic void dark_spotted_image();
        int a;
        for (a = 0; a < IMG_W * IMG_H; a++) begin
            if (($random(seed) & 7) == 0) begin
                model_img[a] = pixel_t'(24 + ($random(seed) & 63));
            end else begin
                model_img[a] = pixel_t'($random(seed) & 3);
            end
        end
    endfunction

    task automatic load_image();
        int a;
        for (a = 0; a < IMG_W * IMG_H; a++) begin
            @(posedge clk);
            #2;
            img_wr = '{we: 1'b1, addr: pix_addr_t'(a), data: model_img[a]};
        end
        @(posedge clk);
        #2;
        img_wr = '0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!done);
    endtask

    task automatic read_keypoints();
        int i;
        for (i = 0; i < model_count; i++) begin
            @(posedge clk);
            #2;
            kpt_rd_addr = kpt_addr_t'(i);
            @(posedge clk);
            @(negedge clk);  // one cycle read latency
            check_keypoint(i, kpt_rd_data, model_kpts[i]);
        end
    endtask

    // one full run, optionally poking start and host writes while busy
    task automatic run_and_check(input logic filt, input logic adapt,
                                 input adapt_mode_t mode, input logic disturb);
        int pulses_before;
        int i;
        compute_blur();
        find_keypoints(model_thresh, filt);
        pulses_before = done_pulses;
        @(posedge clk);
        #2;
        check_busy(busy, 1'b0);
        filter_on  = filt;
        adapt_on   = adapt;
        adapt_mode = mode;
        start      = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        check_busy(busy, 1'b1);
        if (disturb) begin
            repeat (30) @(posedge clk);
            for (i = 0; i < 16; i++) begin
                @(posedge clk);
                #2;
                start  = 1'b1;
                img_wr = '{we: 1'b1, addr: pix_addr_t'($random(seed)),
                           data: pixel_t'($random(seed))};
            end
            @(posedge clk);
            #2;
            start  = 1'b0;
            img_wr = '0;
        end
        wait_done();
        check_busy(busy, 1'b0);
        check_count(kpt_count, kpt_count_t'(model_count));
        read_keypoints();
        repeat (2) @(negedge clk);
        model_thresh = next_thresh(model_thresh, adapt, mode, model_count);
        check_thresh(thresh, model_thresh);
        if (done_pulses != pulses_before + 1) begin
            stop_with_failure("a run did not give exactly one done pulse");
        end
    endtask

    initial begin
        int      run;
        int      filtered;
        int      mode_splits;
        thresh_t prev_thresh;
        thresh_t other_thresh;
        seed         = 31179;
        cycle_count  = 0;
        done_pulses  = 0;
        mode_splits  = 0;
        model_thresh = THRESH_INIT;
        rst_n        = 1'b0;
        start        = 1'b0;
        filter_on    = 1'b0;
        adapt_on     = 1'b0;
        adapt_mode   = MODE_THROUGHPUT;
        img_wr       = '0;
        kpt_rd_addr  = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        random_image();  // plain detection
        load_image();
        run_and_check(1'b0, 1'b0, MODE_THROUGHPUT, 1'b0);

        dark_spotted_image();  // contrast filter
        load_image();
        run_and_check(1'b1, 1'b0, MODE_THROUGHPUT, 1'b0);
        filtered = model_cands;
        find_keypoints(model_thresh, 1'b0);
        if (filtered >= KPT_MAX || model_cands <= filtered) begin
            stop_with_failure("the contrast test image gave the filter nothing to reject");
        end

        bright_noisy_image();  // overflow of the keypoint memory
        load_image();
        run_and_check(1'b0, 1'b0, MODE_THROUGHPUT, 1'b0);
        if (model_cands <= KPT_MAX) begin
            stop_with_failure("the bright test image did not overflow the keypoint memory");
        end

        random_image();  // start and writes while busy
        load_image();
        run_and_check(1'b0, 1'b0, MODE_THROUGHPUT, 1'b1);

        for (run = 0; run < 4; run++) begin
            random_image();
            load_image();
            run_and_check(1'b0, 1'b1, MODE_THROUGHPUT, 1'b0);
        end

        // sparse spots keep the count near the accuracy band
        for (run = 0; run < 4; run++) begin
            dark_spotted_image();
            load_image();
            prev_thresh = model_thresh;
            run_and_check(1'b0, 1'b1, MODE_ACCURACY, 1'b0);
            other_thresh = next_thresh(prev_thresh, 1'b1, MODE_THROUGHPUT, model_count);
            if (other_thresh != model_thresh) begin
                mode_splits++;
            end
        end
        if (mode_splits == 0) begin
            stop_with_failure("the accuracy mode runs never told the two count bands apart");
        end

        random_image();  // adaptation off holds thresh
        load_image();
        run_and_check(1'b0, 1'b0, MODE_ACCURACY, 1'b0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+test
hdl/feature_pkg.sv
hdl/ctrl_pkg.sv
hdl/sync_ram.sv
hdl/gauss_blur.sv
hdl/keypoint_detect.sv
hdl/adaptive_threshold.sv
hdl/phase_ctrl.sv
hdl/feature_core.sv
test/tb_feature_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the feature_core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_feature_core \
    -f all.f \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
